// File: cart_pkg.sv
// Shared download, quirk, cheat-code and Wishbone types for the cartridge loader and its testbench
`default_nettype none

package cart_pkg;

	////////////////////////////////////////////////////////////
	// Download port
	////////////////////////////////////////////////////////////

	// Byte address as sent by the host
	typedef logic [24:0] dl_addr_t;

	// Even-address byte sits in the low half
	typedef logic [15:0] dl_data_t;

	typedef logic [7:0] dl_index_t;

	// One word of the host stream, wr is a single-cycle strobe
	typedef struct packed {
		logic      active;
		dl_index_t index;
		logic      wr;
		dl_addr_t  addr;
		dl_data_t  data;
	} dl_stream_t;

	// Index reserved for cheat-code downloads
	localparam dl_index_t CODE_INDEX = 8'hff;

	// Header words that carry the product ID
	localparam dl_addr_t HDR_ID_FIRST = 25'h000182;
	localparam dl_addr_t HDR_ID_LAST  = 25'h00018a;

	////////////////////////////////////////////////////////////
	// Cartridge and cheat outputs
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic ttn2;
	} cart_quirks_t;

	// Words arrive low half first, in download byte order
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	////////////////////////////////////////////////////////////
	// ROM memory side
	////////////////////////////////////////////////////////////

	typedef logic [23:0] rom_adr_t;
	typedef logic [15:0] rom_data_t;

	// Master outputs of a Wishbone classic write
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		logic [1:0] sel;
		rom_adr_t  adr;
		rom_data_t dat;
	} wb_master_t;

	typedef enum logic {
		idle,
		busy
	} wr_state_t;

endpackage

`default_nettype wire

// File: rom_write_master.sv
// Writes each cart download word to ROM over Wishbone classic and holds the host off meanwhile
`timescale 1ns/1ps
`default_nettype none

module rom_write_master
	import cart_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  dl_stream_t cart,
	output wb_master_t wb,
	input  logic       wb_ack,
	output logic       dl_wait,
	output dl_addr_t   rom_size
);

	wr_state_t state;
	rom_adr_t  adr_q;
	rom_data_t dat_q;
	dl_addr_t  last_addr;
	logic      active_q;
	logic      wr_req;

	assign wr_req = cart.active & cart.wr;

	////////////////////////////////////////////////////////////
	// Write FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (wr_req) state <= busy;
				busy: if (wb_ack) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// Word address and byte-swapped data, taken when the host writes
	always_ff @(posedge clk_sys) begin
		if (wr_req && state == idle) begin
			adr_q <= cart.addr[24:1];
			dat_q <= {cart.data[7:0], cart.data[15:8]};
		end
	end

	always_comb begin
		wb.cyc = (state == busy);
		wb.stb = (state == busy);
		wb.we  = 1'b1;
		wb.sel = 2'b11;
		wb.adr = adr_q;
		wb.dat = dat_q;
	end

	// Host stalls for exactly the bus cycle
	assign dl_wait = wb.cyc;

	////////////////////////////////////////////////////////////
	// ROM size at end of download
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			active_q  <= 1'b0;
			last_addr <= '0;
			rom_size  <= '0;
		end else begin
			active_q <= cart.active;
			if (wr_req && state == idle) last_addr <= cart.addr;
			if (active_q && !cart.active) rom_size <= last_addr + 25'd2;
		end
	end

	// Strobe and its address and data hold until the slave answers
	a_stb_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wb.stb && !wb_ack |=> wb.stb && $stable(wb.adr) && $stable(wb.dat));

	// Host must respect dl_wait
	a_no_wr_busy: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(state == busy) |-> !wr_req);

endmodule

`default_nettype wire

// File: cart_quirk_detect.sv
// Picks the product ID out of the streaming cart header and raises the matching quirk flag
`timescale 1ns/1ps
`default_nettype none

module cart_quirk_detect
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n,
	input  dl_stream_t   cart,
	output cart_quirks_t quirks
);

	// Eight ASCII characters, first character in the top byte
	typedef logic [63:0] product_id_t;

	logic         active_q;
	logic         dl_start;
	logic         wr_en;
	logic [55:0]  id_head;
	product_id_t  full_id;
	cart_quirks_t hit;

	assign dl_start = cart.active & ~active_q;
	assign wr_en    = cart.active & cart.wr;

	////////////////////////////////////////////////////////////
	// ID capture
	////////////////////////////////////////////////////////////

	// File bytes 0x183..0x189, each word stored low byte first
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			case (cart.addr)
				HDR_ID_FIRST: id_head[55:48] <= cart.data[15:8];
				25'h184:      id_head[47:32] <= {cart.data[7:0], cart.data[15:8]};
				25'h186:      id_head[31:16] <= {cart.data[7:0], cart.data[15:8]};
				25'h188:      id_head[15:0]  <= {cart.data[7:0], cart.data[15:8]};
				default: ;
			endcase
		end
	end

	// Last character is the low byte of the final header word
	assign full_id = {id_head, cart.data[7:0]};

	always_comb begin
		hit = '0;
		case (full_id)
			"T-081276", "T-81406 ": hit.sram   = 1'b1;
			"MK-1215 ", "G-4060  ": hit.eeprom = 1'b1;
			"T-113016":             hit.noram  = 1'b1;
			"T-89016 ":             hit.fifo   = 1'b1;
			"T-574023", "T-574013": hit.pier   = 1'b1;
			"TITAN002":             hit.ttn2   = 1'b1;
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Flag register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			quirks   <= '0;
		end else begin
			active_q <= cart.active;
			if (dl_start) begin
				quirks <= '0;
			end else if (wr_en && cart.addr == HDR_ID_LAST) begin
				quirks <= hit;
			end
		end
	end

endmodule

`default_nettype wire

// File: cheat_code_loader.sv
// Collects the eight words of a cheat-code download into one code and strobes it out
`timescale 1ns/1ps
`default_nettype none

module cheat_code_loader
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  dl_stream_t  code,
	output cheat_code_t cheat_code,
	output logic        cheat_valid,
	output logic        cheat_clear
);

	logic       wr_en;
	logic [3:0] offset;

	assign wr_en  = code.active & code.wr;
	assign offset = code.addr[3:0];

	// Low word of each field comes first
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			case (offset)
				4'd0:  cheat_code.flags[15:0]    <= code.data;
				4'd2:  cheat_code.flags[31:16]   <= code.data;
				4'd4:  cheat_code.address[15:0]  <= code.data;
				4'd6:  cheat_code.address[31:16] <= code.data;
				4'd8:  cheat_code.compare[15:0]  <= code.data;
				4'd10: cheat_code.compare[31:16] <= code.data;
				4'd12: cheat_code.replace[15:0]  <= code.data;
				4'd14: cheat_code.replace[31:16] <= code.data;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Code is complete once the replace high word lands
			cheat_valid <= wr_en && offset == 4'd14;
			// First word of the file drops the previous code list
			cheat_clear <= wr_en && code.addr == '0;
		end
	end

	a_even_addr: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wr_en |-> !code.addr[0]);

endmodule

`default_nettype wire

// File: cart_loader_top.sv
// Top of the cart loading front end, splits the host download into cart and cheat-code streams
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n,
	input  dl_stream_t   dl,
	output logic         dl_wait,
	output wb_master_t   wb,
	input  logic         wb_ack,
	output dl_addr_t     rom_size,
	output cart_quirks_t quirks,
	output cheat_code_t  cheat_code,
	output logic         cheat_valid,
	output logic         cheat_clear
);

	logic       code_sel;
	dl_stream_t cart_stream;
	dl_stream_t code_stream;

	// An all-ones index marks a cheat-code file
	assign code_sel = (dl.index == CODE_INDEX);

	always_comb begin
		cart_stream        = dl;
		cart_stream.active = dl.active & ~code_sel;
		code_stream        = dl;
		code_stream.active = dl.active & code_sel;
	end

	rom_write_master rom_write_master_inst (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.cart     (cart_stream),
		.wb       (wb),
		.wb_ack   (wb_ack),
		.dl_wait  (dl_wait),
		.rom_size (rom_size)
	);

	cart_quirk_detect cart_quirk_detect_inst (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.cart    (cart_stream),
		.quirks  (quirks)
	);

	cheat_code_loader cheat_code_loader_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.code        (code_stream),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

endmodule

`default_nettype wire

// File: tb_cart_loader.sv
// Directed testbench for the cart loader top level, with a Wishbone ROM model and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_cart_loader
	import cart_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	// About 950 download words at no more than 8 cycles each need under 80 us
	localparam int WATCHDOG_NS = 200_000;

	logic         clk_sys = 1'b0;
	logic         rst_n = 1'b0;
	dl_stream_t   dl = '0;
	logic         wb_ack = 1'b0;
	logic         dl_wait;
	wb_master_t   wb;
	dl_addr_t     rom_size;
	cart_quirks_t quirks;
	cheat_code_t  cheat_code;
	logic         cheat_valid;
	logic         cheat_clear;

	rom_data_t    rom_mem [rom_adr_t];
	dl_data_t     code_words [8];
	int           errors = 0;
	int           checks = 0;
	int           cycle = 0;
	int           last_wr_cycle = 0;
	int           valid_cycle = 0;
	int           valid_count = 0;
	int           clear_count = 0;
	int           bus_cycles = 0;
	bit           cart_phase = 1'b0;
	bit           code_phase = 1'b0;
	bit           slave_busy = 1'b0;
	int unsigned  ack_left = 0;
	rom_adr_t     held_adr;
	rom_data_t    held_dat;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	cart_loader_top cart_loader_top_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl          (dl),
		.dl_wait     (dl_wait),
		.wb          (wb),
		.wb_ack      (wb_ack),
		.rom_size    (rom_size),
		.quirks      (quirks),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	task automatic expect_equal(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic expect_true(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Error: %s", what);
		end
	endtask

	////////////////////////////////////////////////////////////
	// ROM slave and bus monitor
	////////////////////////////////////////////////////////////

	// Ack comes 0 to 3 cycles after the slave first sees the cycle
	always @(posedge clk_sys) begin
		wb_ack <= 1'b0;
		if (rst_n && wb.cyc && !wb_ack) begin
			if (!slave_busy) begin
				slave_busy = 1'b1;
				ack_left = $urandom_range(3, 0);
				held_adr = wb.adr;
				held_dat = wb.dat;
				bus_cycles++;
				expect_true(wb.stb && wb.we && wb.sel == 2'b11,
					"bus cycle without stb, we or both byte selects");
			end else begin
				expect_true(wb.adr == held_adr && wb.dat == held_dat,
					"bus address or data changed before the acknowledge");
			end
			if (ack_left == 0) begin
				rom_mem[wb.adr] = wb.dat;
				wb_ack <= 1'b1;
				slave_busy = 1'b0;
			end else begin
				ack_left--;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		if (rst_n) begin
			expect_equal("dl_wait", 128'(dl_wait), 128'(wb.cyc));
			if (cheat_valid) begin
				valid_count++;
				valid_cycle = cycle;
			end
			if (cheat_clear) clear_count++;
			if (code_phase) expect_true(!wb.cyc, "bus cycle started during a cheat-code download");
			if (cart_phase) expect_true(!cheat_valid, "cheat_valid pulsed during a cart download");
		end
	end

	////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////

	task automatic start_download(input dl_index_t idx);
		dl.index  <= idx;
		dl.active <= 1'b1;
		cart_phase = (idx != CODE_INDEX);
		code_phase = (idx == CODE_INDEX);
		@(posedge clk_sys);
	endtask

	// Extra cycle lets rom_size settle after active falls
	task automatic end_download();
		dl.active <= 1'b0;
		@(posedge clk_sys);
		@(posedge clk_sys);
		cart_phase = 1'b0;
		code_phase = 1'b0;
	endtask

	task automatic send_word(input dl_addr_t addr, input dl_data_t data);
		dl.wr   <= 1'b1;
		dl.addr <= addr;
		dl.data <= data;
		@(posedge clk_sys);
		last_wr_cycle = cycle;
		dl.wr <= 1'b0;
		@(posedge clk_sys);
		if (dl.index != CODE_INDEX) begin
			expect_true(dl_wait && wb.cyc, "bus cycle did not start one cycle after a cart write");
		end
		while (dl_wait) @(posedge clk_sys);
	endtask

	// Byte at addr in the low half, ID characters at 0x183..0x18A
	function automatic dl_data_t header_word(input dl_addr_t addr, input logic [63:0] id);
		logic [7:0] b [2];
		dl_addr_t a;
		int k;
		for (int i = 0; i < 2; i++) begin
			a = addr + dl_addr_t'(i);
			k = int'(a) - 'h183;
			if (k >= 0 && k < 8) b[i] = id[8 * (7 - k) +: 8];
			else b[i] = 8'($urandom());
		end
		return {b[1], b[0]};
	endfunction

	task automatic stream_header(input logic [63:0] id);
		start_download(8'h00);
		for (int a = 'h100; a < 'h190; a += 2) begin
			send_word(dl_addr_t'(a), header_word(dl_addr_t'(a), id));
			// Flags drop as soon as a new cart download begins
			if (a == 'h100) expect_equal("quirks", 128'(quirks), 128'(0));
		end
		end_download();
	endtask

	task automatic send_code();
		start_download(CODE_INDEX);
		for (int i = 0; i < 8; i++) begin
			code_words[i] = 16'($urandom());
			send_word(dl_addr_t'(2 * i), code_words[i]);
		end
		end_download();
	endtask

	function automatic logic [63:0] table_id(input int k);
		case (k)
			0: return "T-081276";
			1: return "T-81406 ";
			2: return "MK-1215 ";
			3: return "G-4060  ";
			4: return "T-113016";
			5: return "T-89016 ";
			6: return "T-574023";
			7: return "T-574013";
			default: return "TITAN002";
		endcase
	endfunction

	function automatic cart_quirks_t table_flag(input int k);
		cart_quirks_t q;
		q = '0;
		case (k)
			0, 1: q.sram = 1'b1;
			2, 3: q.eeprom = 1'b1;
			4: q.noram = 1'b1;
			5: q.fifo = 1'b1;
			6, 7: q.pier = 1'b1;
			default: q.ttn2 = 1'b1;
		endcase
		return q;
	endfunction

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic check_reset_values();
		expect_equal("{cyc,stb,dl_wait,cheat_valid,cheat_clear,quirks,rom_size}",
			128'({wb.cyc, wb.stb, dl_wait, cheat_valid, cheat_clear, quirks, rom_size}), 128'(0));
	endtask

	task automatic test_rom_load();
		dl_data_t sent [64];
		int cycles_before;
		cycles_before = bus_cycles;
		start_download(8'h00);
		for (int i = 0; i < 64; i++) begin
			sent[i] = 16'($urandom());
			send_word(dl_addr_t'(2 * i), sent[i]);
		end
		end_download();
		expect_equal("bus cycles", 128'(bus_cycles - cycles_before), 128'(64));
		for (int i = 0; i < 64; i++) begin
			expect_true(rom_mem.exists(rom_adr_t'(i)), "ROM word was never written");
			expect_equal($sformatf("rom_mem[0x%0h]", i), 128'(rom_mem[rom_adr_t'(i)]),
				128'({sent[i][7:0], sent[i][15:8]}));
		end
		expect_equal("rom_size", 128'(rom_size), 128'(128));
	endtask

	task automatic test_quirk_table();
		for (int k = 0; k < 9; k++) begin
			stream_header(table_id(k));
			expect_equal("quirks", 128'(quirks), 128'(table_flag(k)));
		end
	endtask

	task automatic test_no_match();
		stream_header("T-574023");
		expect_equal("quirks", 128'(quirks), 128'(table_flag(6)));
		stream_header("ABCDEFGH");
		expect_equal("quirks", 128'(quirks), 128'(0));
	endtask

	task automatic test_cheat_assembly();
		cheat_code_t exp_code;
		int valid_before;
		int clear_before;
		valid_before = valid_count;
		clear_before = clear_count;
		send_code();
		exp_code.flags   = {code_words[1], code_words[0]};
		exp_code.address = {code_words[3], code_words[2]};
		exp_code.compare = {code_words[5], code_words[4]};
		exp_code.replace = {code_words[7], code_words[6]};
		expect_equal("cheat_clear pulses", 128'(clear_count - clear_before), 128'(1));
		expect_equal("cheat_valid pulses", 128'(valid_count - valid_before), 128'(1));
		expect_true(valid_cycle == last_wr_cycle + 1,
			"cheat_valid did not follow the offset 14 word by one cycle");
		expect_equal("cheat_code", 128'(cheat_code), 128'(exp_code));
	endtask

	task automatic test_stream_separation();
		dl_addr_t size_before;
		cart_quirks_t quirks_before;
		int cycles_before;
		stream_header("T-574013");
		expect_equal("rom_size", 128'(rom_size), 128'('h190));
		size_before = rom_size;
		quirks_before = quirks;
		cycles_before = bus_cycles;
		send_code();
		expect_equal("bus cycles", 128'(bus_cycles - cycles_before), 128'(0));
		expect_equal("rom_size", 128'(rom_size), 128'(size_before));
		expect_equal("quirks", 128'(quirks), 128'(quirks_before));
	endtask

	initial begin
		void'($urandom(32'hb4538a64));
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(posedge clk_sys);
		check_reset_values();
		test_rom_load();
		test_quirk_table();
		test_no_match();
		test_cheat_assembly();
		test_stream_separation();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
cart_pkg.sv
rom_write_master.sv
cart_quirk_detect.sv
cheat_code_loader.sv
cart_loader_top.sv
tb_cart_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cart loader testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module tb_cart_loader \
	--Mdir "$BUILD_DIR" \
	-f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_cart_loader" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
